/* hw/ex_defs.svh */
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// Datapath word width
`define EX_DATA_W 16

// Carry-lookahead slice width and number of slices in the ALU adder
`define EX_SLICE_W 4
`define EX_NUM_SLICES (`EX_DATA_W / `EX_SLICE_W)

// Shift and rotate amount from the low bits of the second operand
`define EX_SHAMT_W 4

`endif

/* hw/isa_pkg.sv */
`include "ex_defs.svh"

package isa_pkg;

   typedef logic [`EX_DATA_W-1:0]  word_t;
   typedef logic [`EX_SHAMT_W-1:0] shamt_t;

   // ALU operation as decoded from the instruction
   typedef enum logic [2:0] {
      rol    = 3'b000,
      sll    = 3'b001,
      ror    = 3'b010,
      srl    = 3'b011,
      add    = 3'b100,
      and_op = 3'b101,
      or_op  = 3'b110,
      xor_op = 3'b111
   } alu_op_t;

   // Branch conditions in BEQZ/BNEZ/BLTZ/BGEZ encoding order
   typedef enum logic [1:0] {
      eq  = 2'b00,
      neq = 2'b01,
      ltz = 2'b10,
      gez = 2'b11
   } br_cnd_t;

   // Flag picked by the SEQ/SLT/SLE/SCO style instructions
   typedef enum logic [1:0] {
      ofl  = 2'b00,
      zero = 2'b01,
      lt   = 2'b10,
      lte  = 2'b11
   } set_sel_t;

endpackage

/* hw/pipe_pkg.sv */
package pipe_pkg;

   import isa_pkg::*;

   // Forwarding selects from the hazard unit
   typedef struct packed {
      logic ex_rs;
      logic ex_rt;
      logic mem_rs;
      logic mem_rt;
      logic mem_st;
   } fwd_sel_t;

   // ID/EX pipeline register contents
   typedef struct packed {
      logic     valid;
      word_t    opnd_1;
      word_t    opnd_2;
      word_t    st_data;
      word_t    sext_imm;
      word_t    pc_inc;
      alu_op_t  alu_op;
      logic     alu_cin;
      logic     inv_a;
      logic     inv_b;
      logic     sign;
      set_sel_t set_sel;
      br_cnd_t  br_cnd;
      logic     br_instr;
      logic     jmp_instr;
      logic     jmp_reg_instr;
      fwd_sel_t fwd;
   } id_ex_t;

   // EX/MEM pipeline register contents
   typedef struct packed {
      logic  valid;
      word_t alu_out;
      word_t st_data;
      word_t lbi;
      word_t slbi;
      word_t new_pc;
      logic  set;
      logic  ofl;
      logic  take_new_pc;
   } ex_mem_t;

endpackage

/* hw/operand_fwd.sv */
`timescale 1ns/100ps

module operand_fwd (
   input  pipe_pkg::fwd_sel_t fwd,
   input  isa_pkg::word_t     opnd_1,
   input  isa_pkg::word_t     opnd_2,
   input  isa_pkg::word_t     st_data,
   input  isa_pkg::word_t     ex_val,
   input  isa_pkg::word_t     mem_val,
   output isa_pkg::word_t     op_a,
   output isa_pkg::word_t     op_b,
   output isa_pkg::word_t     st_fwd
);

   // Rs operand with the younger EX result ahead of MEM
   always_comb begin
      if (fwd.ex_rs) begin
         op_a = ex_val;
      end else if (fwd.mem_rs) begin
         op_a = mem_val;
      end else begin
         op_a = opnd_1;
      end
   end

   // Rt operand with the same priority
   always_comb begin
      if (fwd.ex_rt) begin
         op_b = ex_val;
      end else if (fwd.mem_rt) begin
         op_b = mem_val;
      end else begin
         op_b = opnd_2;
      end
   end

   // Store data only ever needs the MEM stage value
   assign st_fwd = fwd.mem_st ? mem_val : st_data;

endmodule

/* hw/cla_4b.sv */
`timescale 1ns/100ps

module cla_4b (
   input  logic [3:0] a,
   input  logic [3:0] b,
   input  logic       cin,
   output logic [3:0] sum,
   output logic       g,
   output logic       p
);

   logic [3:0] gb;
   logic [3:0] pb;
   logic [3:0] c;

   // Bit level generate and propagate
   assign gb = a & b;
   assign pb = a ^ b;

   // Lookahead carries into each bit
   assign c[0] = cin;
   assign c[1] = gb[0] | (pb[0] & cin);
   assign c[2] = gb[1] | (pb[1] & gb[0]) | (pb[1] & pb[0] & cin);
   assign c[3] = gb[2] | (pb[2] & gb[1]) | (pb[2] & pb[1] & gb[0])
               | (pb[2] & pb[1] & pb[0] & cin);

   assign sum = pb ^ c;

   // Group terms for the next level of lookahead
   assign g = gb[3] | (pb[3] & gb[2]) | (pb[3] & pb[2] & gb[1])
            | (pb[3] & pb[2] & pb[1] & gb[0]);
   assign p = &pb;

endmodule

/* hw/alu.sv */
`timescale 1ns/100ps
`include "ex_defs.svh"

module alu (
   input  isa_pkg::word_t   in_a,
   input  isa_pkg::word_t   in_b,
   input  isa_pkg::alu_op_t op,
   input  logic             cin,
   input  logic             inv_a,
   input  logic             inv_b,
   input  logic             sign,
   output isa_pkg::word_t   result,
   output logic             zero,
   output logic             ofl,
   output logic             ltz,
   output logic             lteq
);

   import isa_pkg::*;

   localparam int W  = `EX_DATA_W;
   localparam int SW = `EX_SLICE_W;
   localparam int NS = `EX_NUM_SLICES;

   word_t              a_in;
   word_t              b_in;
   word_t              sum;
   logic [NS:0]        carry;
   logic [NS-1:0]      grp_g;
   logic [NS-1:0]      grp_p;
   logic               cout;
   logic               sofl;
   shamt_t             shamt;
   logic [2*W-1:0]     rol_ext;
   logic [2*W-1:0]     ror_ext;

   // Operand inversion for subtraction and the inverted logic forms
   assign a_in = inv_a ? ~in_a : in_a;
   assign b_in = inv_b ? ~in_b : in_b;

   assign carry[0] = cin;

   genvar i;
   generate
      for (i = 0; i < NS; i++) begin : g_slice
         cla_4b cla_4b_inst (
            .a   (a_in[i*SW +: SW]),
            .b   (b_in[i*SW +: SW]),
            .cin (carry[i]),
            .sum (sum[i*SW +: SW]),
            .g   (grp_g[i]),
            .p   (grp_p[i])
         );
         // Carry into the next slice from group terms
         assign carry[i+1] = grp_g[i] | (grp_p[i] & carry[i]);
      end
   endgenerate

   assign cout = carry[NS];

   // Signed overflow when both inputs agree in sign and the sum does not
   assign sofl = (a_in[W-1] == b_in[W-1]) && (sum[W-1] != a_in[W-1]);

   // Rotates via a doubled word
   assign shamt   = in_b[`EX_SHAMT_W-1:0];
   assign rol_ext = {in_a, in_a} << shamt;
   assign ror_ext = {in_a, in_a} >> shamt;

   always_comb begin
      case (op)
         rol:     result = rol_ext[2*W-1:W];
         sll:     result = in_a << shamt;
         ror:     result = ror_ext[W-1:0];
         srl:     result = in_a >> shamt;
         add:     result = sum;
         and_op:  result = a_in & b_in;
         or_op:   result = a_in | b_in;
         xor_op:  result = a_in ^ b_in;
         default: result = sum;
      endcase
   end

   // Flags
   assign zero = (result == '0);
   assign ofl  = sign ? sofl : cout;
   // Unsigned less-than is a borrow with no carry out of a - b
   assign ltz  = sign ? (sum[W-1] ^ sofl) : ~cout;
   assign lteq = ltz | zero;

endmodule

/* hw/branch_unit.sv */
`timescale 1ns/100ps
`include "ex_defs.svh"

module branch_unit (
   input  isa_pkg::word_t    op_a,
   input  isa_pkg::word_t    sext_imm,
   input  isa_pkg::word_t    pc_inc,
   input  isa_pkg::word_t    alu_out,
   input  logic              zero,
   input  logic              ofl,
   input  logic              ltz,
   input  logic              lteq,
   input  isa_pkg::br_cnd_t  br_cnd,
   input  isa_pkg::set_sel_t set_sel,
   input  logic              br_instr,
   input  logic              jmp_instr,
   input  logic              jmp_reg_instr,
   output logic              take_new_pc,
   output logic              set,
   output isa_pkg::word_t    new_pc,
   output isa_pkg::word_t    lbi,
   output isa_pkg::word_t    slbi
);

   import isa_pkg::*;

   logic [3:0] cnd_vec;
   logic [3:0] flag_vec;
   logic       take_br;
   word_t      pc_target;

   // Condition table indexed by br_cnd from eq in bit 0 to gez in bit 3
   assign cnd_vec = {~op_a[`EX_DATA_W-1], op_a[`EX_DATA_W-1], ~zero, zero};
   assign take_br = cnd_vec[br_cnd];

   assign take_new_pc = jmp_instr | jmp_reg_instr | (br_instr & take_br);

   // PC relative target for branches and immediate jumps
   assign pc_target = pc_inc + sext_imm;
   assign new_pc    = jmp_reg_instr ? alu_out : pc_target;

   // Flag table indexed by set_sel from ofl in bit 0 to lte in bit 3
   assign flag_vec = {lteq, ltz, zero, ofl};
   assign set      = flag_vec[set_sel];

   // Load immediate forms
   assign lbi  = sext_imm;
   assign slbi = {op_a[7:0], sext_imm[7:0]};

endmodule

/* hw/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage (
   input  logic              clk,
   input  logic              rst_n,
   input  pipe_pkg::id_ex_t  id_ex,
   input  isa_pkg::word_t    mem_fwd_val,
   output pipe_pkg::ex_mem_t ex_mem
);

   import isa_pkg::*;
   import pipe_pkg::*;

   word_t   op_a;
   word_t   op_b;
   word_t   st_fwd;
   word_t   alu_res;
   logic    alu_zero;
   logic    alu_ofl;
   logic    alu_ltz;
   logic    alu_lteq;
   ex_mem_t ex_mem_d;

   // EX forwarding source is the result already sitting in EX/MEM
   operand_fwd operand_fwd_inst (
      .fwd     (id_ex.fwd),
      .opnd_1  (id_ex.opnd_1),
      .opnd_2  (id_ex.opnd_2),
      .st_data (id_ex.st_data),
      .ex_val  (ex_mem.alu_out),
      .mem_val (mem_fwd_val),
      .op_a    (op_a),
      .op_b    (op_b),
      .st_fwd  (st_fwd)
   );

   alu alu_inst (
      .in_a   (op_a),
      .in_b   (op_b),
      .op     (id_ex.alu_op),
      .cin    (id_ex.alu_cin),
      .inv_a  (id_ex.inv_a),
      .inv_b  (id_ex.inv_b),
      .sign   (id_ex.sign),
      .result (alu_res),
      .zero   (alu_zero),
      .ofl    (alu_ofl),
      .ltz    (alu_ltz),
      .lteq   (alu_lteq)
   );

   branch_unit branch_unit_inst (
      .op_a          (op_a),
      .sext_imm      (id_ex.sext_imm),
      .pc_inc        (id_ex.pc_inc),
      .alu_out       (alu_res),
      .zero          (alu_zero),
      .ofl           (alu_ofl),
      .ltz           (alu_ltz),
      .lteq          (alu_lteq),
      .br_cnd        (id_ex.br_cnd),
      .set_sel       (id_ex.set_sel),
      .br_instr      (id_ex.br_instr),
      .jmp_instr     (id_ex.jmp_instr),
      .jmp_reg_instr (id_ex.jmp_reg_instr),
      .take_new_pc   (ex_mem_d.take_new_pc),
      .set           (ex_mem_d.set),
      .new_pc        (ex_mem_d.new_pc),
      .lbi           (ex_mem_d.lbi),
      .slbi          (ex_mem_d.slbi)
   );

   assign ex_mem_d.valid   = id_ex.valid;
   assign ex_mem_d.alu_out = alu_res;
   assign ex_mem_d.st_data = st_fwd;
   assign ex_mem_d.ofl     = alu_ofl;

   // EX/MEM register where a bubble keeps the old payload
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ex_mem <= '0;
      end else if (id_ex.valid) begin
         ex_mem <= ex_mem_d;
      end else begin
         ex_mem.valid       <= 1'b0;
         ex_mem.take_new_pc <= 1'b0;
      end
   end

endmodule

/* bench/ex_checker.sv */
`timescale 1ns/100ps

module ex_checker (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              chk_en,
   input  logic              report,
   input  string             test_name,
   input  pipe_pkg::ex_mem_t exp_out,
   input  pipe_pkg::ex_mem_t ex_mem,
   output int                n_done,
   output int                n_fail
);

   import pipe_pkg::*;

   logic    pend_en;
   string   pend_name;
   ex_mem_t pend_exp;
   int      line_errs;

   task automatic check_field(input string fld, input logic [15:0] exp_v,
                              input logic [15:0] act_v);
      if (act_v !== exp_v) begin
         $display("[ERROR] %s %s expected %h actual %h", pend_name, fld, exp_v, act_v);
         line_errs++;
      end
   endtask

   // Expectation belongs to the result registered one clock later
   always @(posedge clk) begin
      if (!rst_n) begin
         pend_en = 1'b0;
      end else begin
         pend_en = chk_en;
      end
      pend_name = test_name;
      pend_exp  = exp_out;
   end

   // ex_mem is settled at the falling edge
   always @(negedge clk) begin
      if (!rst_n) begin
         n_done = 0;
         n_fail = 0;
      end else if (pend_en) begin
         line_errs = 0;
         check_field("valid", 16'(pend_exp.valid), 16'(ex_mem.valid));
         check_field("alu_out", pend_exp.alu_out, ex_mem.alu_out);
         check_field("st_data", pend_exp.st_data, ex_mem.st_data);
         check_field("lbi", pend_exp.lbi, ex_mem.lbi);
         check_field("slbi", pend_exp.slbi, ex_mem.slbi);
         check_field("new_pc", pend_exp.new_pc, ex_mem.new_pc);
         check_field("set", 16'(pend_exp.set), 16'(ex_mem.set));
         check_field("ofl", 16'(pend_exp.ofl), 16'(ex_mem.ofl));
         check_field("take_new_pc", 16'(pend_exp.take_new_pc), 16'(ex_mem.take_new_pc));
         if (line_errs == 0) begin
            $display("test %s ok", pend_name);
         end else begin
            n_fail++;
            $display("test %s failed with %0d wrong fields", pend_name, line_errs);
         end
         n_done++;
      end
   end

   always @(posedge report) begin
      $display("Checked %0d tests: %0d passed, %0d failed", n_done, n_done - n_fail, n_fail);
   end

endmodule

/* bench/execute_tb.sv */
`timescale 1ns/100ps

module execute_tb;

   import isa_pkg::*;
   import pipe_pkg::*;

   logic    clk;
   logic    rst_n;
   id_ex_t  id_ex;
   word_t   mem_fwd_val;
   ex_mem_t ex_mem;
   ex_mem_t exp_out;
   string   exp_name;
   logic    chk_en;
   logic    report;
   logic    load_ok;
   int      n_done;
   int      n_fail;
   int      n_lines;

   // One entry per trace line
   id_ex_t  stim_q[$];
   word_t   mem_q[$];
   ex_mem_t exp_q[$];
   string   name_q[$];

   always #50 clk = ~clk;

   execute_stage execute_stage_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .id_ex       (id_ex),
      .mem_fwd_val (mem_fwd_val),
      .ex_mem      (ex_mem)
   );

   ex_checker ex_checker_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .chk_en    (chk_en),
      .report    (report),
      .test_name (exp_name),
      .exp_out   (exp_out),
      .ex_mem    (ex_mem),
      .n_done    (n_done),
      .n_fail    (n_fail)
   );

   task automatic load_trace();
      int          fd;
      int          cnt;
      string       line;
      string       nm;
      logic        v;
      logic        ev;
      word_t       o1, o2, st, sx, pc, mem;
      word_t       ealu, est, elbi, eslbi, enpc;
      logic [2:0]  op;
      logic [3:0]  cias;
      logic [1:0]  ss;
      logic [1:0]  bc;
      logic [2:0]  bjr;
      logic [4:0]  fw;
      logic [2:0]  sot;
      id_ex_t      stim;
      ex_mem_t     expv;
      load_ok = 1'b1;
      fd = $fopen("bench/ex_trace.txt", "r");
      if (fd == 0) begin
         $display("Could not open the trace file bench/ex_trace.txt");
         load_ok = 1'b0;
      end else begin
         while ($fgets(line, fd) != 0) begin
            // Comment and blank lines
            if (line.len() < 2 || line.getc(0) == "#") continue;
            cnt = $sscanf(line,
               "%s %h %h %h %h %h %h %h %b %h %h %b %b %h %h %h %h %h %h %h %b",
               nm, v, o1, o2, st, sx, pc, op, cias, ss, bc, bjr, fw, mem,
               ev, ealu, est, elbi, eslbi, enpc, sot);
            if (cnt != 21) begin
               $display("Malformed trace line: %s", line);
               load_ok = 1'b0;
            end else begin
               stim               = '0;
               stim.valid         = v;
               stim.opnd_1        = o1;
               stim.opnd_2        = o2;
               stim.st_data       = st;
               stim.sext_imm      = sx;
               stim.pc_inc        = pc;
               stim.alu_op        = alu_op_t'(op);
               stim.alu_cin       = cias[3];
               stim.inv_a         = cias[2];
               stim.inv_b         = cias[1];
               stim.sign          = cias[0];
               stim.set_sel       = set_sel_t'(ss);
               stim.br_cnd        = br_cnd_t'(bc);
               stim.br_instr      = bjr[2];
               stim.jmp_instr     = bjr[1];
               stim.jmp_reg_instr = bjr[0];
               stim.fwd           = fwd_sel_t'(fw);
               expv.valid         = ev;
               expv.alu_out       = ealu;
               expv.st_data       = est;
               expv.lbi           = elbi;
               expv.slbi          = eslbi;
               expv.new_pc        = enpc;
               expv.set           = sot[2];
               expv.ofl           = sot[1];
               expv.take_new_pc   = sot[0];
               stim_q.push_back(stim);
               mem_q.push_back(mem);
               exp_q.push_back(expv);
               name_q.push_back(nm);
            end
         end
         $fclose(fd);
         if (name_q.size() == 0) begin
            $display("The trace file holds no tests");
            load_ok = 1'b0;
         end
      end
      n_lines = name_q.size();
   endtask

   // Inputs and their expectations change 1 ns after the edge
   task automatic drive_line(input int idx);
      @(posedge clk);
      #1;
      id_ex       = stim_q[idx];
      mem_fwd_val = mem_q[idx];
      exp_out     = exp_q[idx];
      exp_name    = name_q[idx];
      chk_en      = 1'b1;
   endtask

   initial begin
      clk         = 1'b0;
      rst_n       = 1'b0;
      id_ex       = '0;
      mem_fwd_val = '0;
      exp_out     = '0;
      exp_name    = "";
      chk_en      = 1'b0;
      report      = 1'b0;
      n_lines     = 0;
      load_trace();
      if (!load_ok) begin
         $display("TEST RESULT: FAIL");
         $finish;
      end else begin
         repeat (16) @(posedge clk);
         #1;
         rst_n = 1'b1;
         for (int i = 0; i < n_lines; i++) begin
            drive_line(i);
         end
         @(posedge clk);
         #1;
         id_ex  = '0;
         chk_en = 1'b0;
         wait (n_done == n_lines);
         report = 1'b1;
         #1;
         if (n_fail == 0) begin
            $display("TEST RESULT: PASS");
         end else begin
            $display("TEST RESULT: FAIL");
         end
         $finish;
      end
   end

   // Reset plus one cycle per trace line and some slack
   initial begin
      wait (n_lines > 0);
      #((16 + n_lines + 10) * 100);
      $display("Run timed out before all tests were checked");
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

/* bench/ex_trace.txt */
# name v opnd_1 opnd_2 st_data sext pc_inc op cias ss bc bjr fwd mem_fwd, then expected: v alu_out
# st_data lbi slbi new_pc sot; cias = cin inv_a inv_b sign, bjr = br jmp jr, sot = set ofl take
# op 0 rol 1 sll 2 ror 3 srl 4 add 5 and 6 or 7 xor; fwd = ex_rs ex_rt mem_rs mem_rt mem_st
rst        0 0000 0000 0000 0000 0000 0 0000 0 0 000 00000 0000 0 0000 0000 0000 0000 0000 000
add        1 1234 0111 aaaa 0000 0000 4 0000 0 0 000 00000 0000 1 1345 aaaa 0000 3400 0000 000
add_cin    1 00ff 0001 0000 0000 0000 4 1000 2 0 000 00000 0000 1 0101 0000 0000 ff00 0000 100
sub        1 0005 0003 0000 0000 0000 4 1011 3 0 000 00000 0000 1 0002 0000 0000 0500 0000 000
sub_zero   1 0007 0007 0000 0000 0000 4 1011 1 0 000 00000 0000 1 0000 0000 0000 0700 0000 100
sub_borrow 1 0003 0005 0000 0000 0000 4 1010 2 0 000 00000 0000 1 fffe 0000 0000 0300 0000 100
add_carry  1 ffff 0002 0000 0000 0000 4 0000 0 0 000 00000 0000 1 0001 0000 0000 ff00 0000 110
add_sovf   1 7fff 0001 0000 0000 0000 4 0001 0 0 000 00000 0000 1 8000 0000 0000 ff00 0000 110
sub_sovf   1 8000 0001 0000 0000 0000 4 1011 2 0 000 00000 0000 1 7fff 0000 0000 0000 0000 110
sle_equal  1 fffe fffe 0000 0000 0000 4 1011 3 0 000 00000 0000 1 0000 0000 0000 fe00 0000 100
sle_gt     1 0003 fffd 0000 0000 0000 4 1011 3 0 000 00000 0000 1 0006 0000 0000 0300 0000 000
rol_4      1 1234 0004 0000 0000 0000 0 0000 0 0 000 00000 0000 1 2341 0000 0000 3400 0000 000
rol_0      1 8001 0010 0000 0000 0000 0 0000 0 0 000 00000 0000 1 8001 0000 0000 0100 0000 000
sll_3      1 f00f 0003 0000 0000 0000 1 0000 0 0 000 00000 0000 1 8078 0000 0000 0f00 0000 000
ror_1      1 0001 0001 0000 0000 0000 2 0000 0 0 000 00000 0000 1 8000 0000 0000 0100 0000 000
ror_12     1 abcd 000c 0000 0000 0000 2 0000 0 0 000 00000 0000 1 bcda 0000 0000 cd00 0000 000
srl_15     1 8000 000f 0000 0000 0000 3 0000 0 0 000 00000 0000 1 0001 0000 0000 0000 0000 000
srl_8      1 ffff 0008 0000 0000 0000 3 0000 0 0 000 00000 0000 1 00ff 0000 0000 ff00 0000 110
and        1 f0f0 ff00 0000 0000 0000 5 0000 1 0 000 00000 0000 1 f000 0000 0000 f000 0000 010
or         1 0f0f 00ff 0000 0000 0000 6 0000 1 0 000 00000 0000 1 0fff 0000 0000 0f00 0000 000
xor_zero   1 5a5a 5a5a 0000 0000 0000 7 0000 1 0 000 00000 0000 1 0000 0000 0000 5a00 0000 100
and_invb   1 ffff 00f0 0000 0000 0000 5 0010 1 0 000 00000 0000 1 ff0f 0000 0000 ff00 0000 010
fwd_base   1 0100 0020 0000 0000 0000 4 0000 0 0 000 00000 0000 1 0120 0000 0000 0000 0000 000
fwd_ex_rs  1 dead 0001 0000 00c3 0000 4 0000 0 0 000 10000 0000 1 0121 0000 00c3 20c3 00c3 000
fwd_mem_rt 1 0002 beef 0000 0000 0000 4 0000 0 0 000 00010 0030 1 0032 0000 0000 0200 0000 000
fwd_both   1 1111 2222 0000 0000 0000 4 0000 0 0 000 11110 5555 1 0064 0000 0000 3200 0000 000
fwd_store  1 0001 0001 1111 0000 0000 4 0000 0 0 000 00001 4321 1 0002 4321 0000 0100 0000 000
fwd_ex_sub 1 0100 ffff 0000 0000 0000 4 1011 2 0 000 01000 0000 1 00fe 0000 0000 0000 0000 000
beq_t      1 0000 0000 0000 0020 0010 4 0000 0 0 100 00000 0000 1 0000 0000 0020 0020 0030 001
beq_nt     1 0005 0000 0000 0020 0010 4 0000 0 0 100 00000 0000 1 0005 0000 0020 0520 0030 000
bne_t      1 0005 0000 0000 0020 0010 4 0000 0 1 100 00000 0000 1 0005 0000 0020 0520 0030 001
bne_nt     1 0000 0000 0000 0020 0010 4 0000 0 1 100 00000 0000 1 0000 0000 0020 0020 0030 000
bltz_t     1 8000 0000 0000 fff8 0100 4 0000 0 2 100 00000 0000 1 8000 0000 fff8 00f8 00f8 001
bltz_nt    1 0001 0000 0000 fff8 0100 4 0000 0 2 100 00000 0000 1 0001 0000 fff8 01f8 00f8 000
bgez_t     1 0000 0000 0000 0020 0010 4 0000 0 3 100 00000 0000 1 0000 0000 0020 0020 0030 001
bgez_nt    1 ffff 0000 0000 0020 0010 4 0000 0 3 100 00000 0000 1 ffff 0000 0020 ff20 0030 000
jmp        1 0000 0000 0000 0100 0202 4 0000 0 0 010 00000 0000 1 0000 0000 0100 0000 0302 001
jmp_reg    1 4000 0008 0000 0008 0002 4 0000 0 0 001 00000 0000 1 4008 0000 0008 0008 4008 001
bubble     0 0000 0000 0000 0000 0000 0 0000 0 0 000 00000 0000 0 4008 0000 0008 0008 4008 000
chain_0    1 0001 0001 0000 0000 0000 4 0000 0 0 000 00000 0000 1 0002 0000 0000 0100 0000 000
chain_1    1 0000 0003 0000 0000 0000 4 0000 0 0 000 10000 0000 1 0005 0000 0000 0200 0000 000
chain_2    1 0000 0007 0000 0000 0000 4 0000 0 0 000 10000 0000 1 000c 0000 0000 0500 0000 000
chain_3    1 0000 0000 0000 0000 0000 4 0000 0 0 000 11000 0000 1 0018 0000 0000 0c00 0000 000
chain_4    1 0000 fff0 0000 0000 0000 4 0000 0 0 000 10000 0000 1 0008 0000 0000 1800 0000 110

/* sim.f */
+incdir+hw
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/operand_fwd.sv
hw/cla_4b.sv
hw/alu.sv
hw/branch_unit.sv
hw/execute_stage.sv
bench/ex_checker.sv
bench/execute_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -f sim.f \
   --top-module execute_tb -o execute_tb

out=$(./obj_dir/execute_tb)
echo "$out"

if echo "$out" | grep -q "TEST RESULT: PASS"; then
   exit 0
fi
exit 1
